// ==== hw/uart_pkg.sv ====
// shared widths, register map and state types of the axi4-lite uart, imported by every rtl module
`default_nettype none

package uart_pkg;

  typedef logic [31:0] axi_data_t;    // bus data word
  typedef logic [4:0]  axi_addr_t;    // byte address, 8 words
  typedef logic [3:0]  axi_id_t;
  typedef logic [1:0]  axi_resp_t;
  typedef logic [7:0]  uart_byte_t;
  typedef logic [15:0] baud_div_t;    // clock cycles per serial bit
  typedef logic [3:0]  fifo_level_t;  // 0 to FIFO_DEPTH

  localparam int FIFO_DEPTH = 8;

  // word index, taken from address bits 4 to 2
  localparam logic [2:0] REG_RBR_THR  = 3'd0;
  localparam logic [2:0] REG_IER      = 3'd1;
  localparam logic [2:0] REG_LCR      = 3'd3;
  localparam logic [2:0] REG_LSR      = 3'd5;
  localparam logic [2:0] REG_BAUD_DIV = 3'd7;  // visible only with dlab set

  localparam int LCR_DLAB_BIT = 7;
  localparam int LSR_DR_BIT   = 0;
  localparam int LSR_THRE_BIT = 5;
  localparam int LSR_TEMT_BIT = 6;

  localparam axi_resp_t RESP_OKAY     = 2'b00;
  localparam baud_div_t BAUD_DIV_INIT = 16'd434;  // 115200 baud from 50 MHz

  typedef enum logic {RD_IDLE, RD_RESP} rd_state_e;
  typedef enum logic {WR_IDLE, WR_RESP} wr_state_e;

  // shared by the transmitter and the receiver
  typedef enum logic [1:0] {
    SER_IDLE,
    SER_START,
    SER_DATA,
    SER_STOP
  } ser_state_e;

endpackage

`default_nettype wire

// ==== hw/uart_fifo.sv ====
// circular byte FIFO with push and pop strobes, one instance per serial direction
`timescale 1ns/1ps
`default_nettype none

module uart_fifo import uart_pkg::*; (
  input  logic       fixed_clk_i,
  input  logic       axi_aresetn_i,
  input  logic       push_i,
  input  logic       pop_i,
  input  uart_byte_t data_i,
  output uart_byte_t data_o,
  output logic       full_o,
  output logic       empty_o
);

  uart_byte_t                      mem [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr_q;
  fifo_level_t                     count_q;
  logic                            push_ok;
  logic                            pop_ok;

  assign full_o  = (count_q == fifo_level_t'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  assign push_ok = push_i && !full_o;  // push on full is dropped
  assign pop_ok  = pop_i && !empty_o;
  assign data_o  = mem[rd_ptr_q];      // front entry

  always_ff @(posedge fixed_clk_i) begin
    if (push_ok) mem[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at depth
      if (pop_ok) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
// serial transmitter, pops the tx FIFO and sends 8n1 frames at the programmed divisor
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_pkg::*; (
  input  logic       fixed_clk_i,
  input  logic       axi_aresetn_i,
  input  baud_div_t  baud_div_i,
  input  logic       fifo_empty_i,
  input  uart_byte_t fifo_data_i,
  output logic       fifo_pop_o,
  output logic       busy_o,
  output logic       uart_tx_o
);

  ser_state_e state_q;
  baud_div_t  cnt_q;
  logic [2:0] idx_q;
  uart_byte_t shift_q;
  logic       bit_done;

  assign bit_done   = (cnt_q >= baud_div_t'(baud_div_i - 1'b1));
  assign fifo_pop_o = (state_q == SER_IDLE) && !fifo_empty_i;
  assign busy_o     = (state_q != SER_IDLE);

  always_ff @(posedge fixed_clk_i) begin
    if (fifo_pop_o) shift_q <= fifo_data_i;
    else if (bit_done && (state_q == SER_START || state_q == SER_DATA))
      shift_q <= shift_q >> 1;  // lsb first
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      state_q   <= SER_IDLE;
      cnt_q     <= '0;
      idx_q     <= '0;
      uart_tx_o <= 1'b1;  // line idles high
    end else begin
      cnt_q <= bit_done ? '0 : cnt_q + 1'b1;
      case (state_q)
        SER_IDLE: begin
          cnt_q <= '0;
          if (fifo_pop_o) begin
            uart_tx_o <= 1'b0;  // start bit
            state_q   <= SER_START;
          end
        end
        SER_START: begin
          if (bit_done) begin
            idx_q     <= '0;
            uart_tx_o <= shift_q[0];
            state_q   <= SER_DATA;
          end
        end
        SER_DATA: begin
          if (bit_done) begin
            if (idx_q == 3'd7) begin
              uart_tx_o <= 1'b1;  // stop bit
              state_q   <= SER_STOP;
            end else begin
              idx_q     <= idx_q + 1'b1;
              uart_tx_o <= shift_q[0];
            end
          end
        end
        default: if (bit_done) state_q <= SER_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/uart_rx.sv ====
// serial receiver, samples 8n1 frames mid-bit and pushes good bytes into the rx FIFO
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_pkg::*; (
  input  logic       fixed_clk_i,
  input  logic       axi_aresetn_i,
  input  baud_div_t  baud_div_i,
  input  logic       uart_rx_i,
  output logic       push_o,
  output uart_byte_t data_o
);

  logic       rx_meta_q;
  logic       rx_sync_q;
  logic       rx_prev_q;
  ser_state_e state_q;
  baud_div_t  cnt_q;
  logic [2:0] idx_q;
  uart_byte_t shift_q;
  logic       half_done;
  logic       bit_done;

  assign half_done = (cnt_q >= baud_div_t'((baud_div_i >> 1) - 1'b1));
  assign bit_done  = (cnt_q >= baud_div_t'(baud_div_i - 1'b1));

  // frames with a low stop bit never reach the fifo
  assign push_o = (state_q == SER_STOP) && bit_done && rx_sync_q;
  assign data_o = shift_q;

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      rx_meta_q <= uart_rx_i;  // two-flop synchronizer
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;  // for edge detect
    end
  end

  always_ff @(posedge fixed_clk_i) begin
    if (state_q == SER_DATA && bit_done) shift_q <= {rx_sync_q, shift_q[7:1]};
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      state_q <= SER_IDLE;
      cnt_q   <= '0;
      idx_q   <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
      case (state_q)
        SER_IDLE: begin
          cnt_q <= '0;
          if (rx_prev_q && !rx_sync_q) state_q <= SER_START;  // falling edge
        end
        SER_START: begin
          if (half_done) begin
            cnt_q   <= '0;
            idx_q   <= '0;
            state_q <= rx_sync_q ? SER_IDLE : SER_DATA;  // glitch if high again
          end
        end
        SER_DATA: begin
          if (bit_done) begin
            cnt_q <= '0;
            if (idx_q == 3'd7) state_q <= SER_STOP;
            else idx_q <= idx_q + 1'b1;
          end
        end
        default: if (bit_done) state_q <= SER_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/axil_uart_regs.sv ====
// axi4-lite slave with independent read and write FSMs, holding the uart control registers
`timescale 1ns/1ps
`default_nettype none

module axil_uart_regs import uart_pkg::*; (
  input  logic       fixed_clk_i,
  input  logic       axi_aresetn_i,
  input  axi_addr_t  axi_awaddr_i,
  input  axi_id_t    axi_awid_i,
  input  logic       axi_awvalid_i,
  output logic       axi_awready_o,
  input  axi_data_t  axi_wdata_i,
  input  logic       axi_wvalid_i,
  output logic       axi_wready_o,
  output logic       axi_bvalid_o,
  output axi_id_t    axi_bid_o,
  output axi_resp_t  axi_bresp_o,
  input  logic       axi_bready_i,
  input  axi_addr_t  axi_araddr_i,
  input  axi_id_t    axi_arid_i,
  input  logic       axi_arvalid_i,
  output logic       axi_arready_o,
  output logic       axi_rvalid_o,
  output axi_id_t    axi_rid_o,
  output axi_data_t  axi_rdata_o,
  output axi_resp_t  axi_rresp_o,
  input  logic       axi_rready_i,
  output logic       tx_push_o,
  output uart_byte_t tx_data_o,
  input  logic       tx_full_i,
  input  logic       tx_empty_i,
  input  logic       tx_busy_i,
  output logic       rx_pop_o,
  input  logic       rx_empty_i,
  input  uart_byte_t rx_data_i,
  output baud_div_t  baud_div_o,
  output logic       read_interrupt_o
);

  wr_state_e  wr_state_q;
  rd_state_e  rd_state_q;
  logic [2:0] wr_idx;
  logic [2:0] rd_idx;
  logic       wr_go;
  logic       rd_go;
  logic       ier_q;
  logic       dlab_q;
  axi_data_t  lsr_word;
  axi_data_t  rd_word;

  assign wr_idx = axi_awaddr_i[4:2];
  assign rd_idx = axi_araddr_i[4:2];

  // a thr write with dlab clear waits for space in the tx fifo
  assign wr_go = (wr_state_q == WR_IDLE) && axi_awvalid_i && axi_wvalid_i &&
                 !((wr_idx == REG_RBR_THR) && !dlab_q && tx_full_i);
  assign rd_go = (rd_state_q == RD_IDLE) && axi_arvalid_i;

  assign tx_push_o = wr_go && (wr_idx == REG_RBR_THR) && !dlab_q;
  assign tx_data_o = axi_wdata_i[7:0];  // low byte only
  assign rx_pop_o  = rd_go && (rd_idx == REG_RBR_THR) && !dlab_q && !rx_empty_i;

  assign axi_bresp_o = RESP_OKAY;
  assign axi_rresp_o = RESP_OKAY;

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      wr_state_q    <= WR_IDLE;
      axi_awready_o <= 1'b0;
      axi_wready_o  <= 1'b0;
      axi_bvalid_o  <= 1'b0;
    end else begin
      case (wr_state_q)
        WR_IDLE: begin
          if (wr_go) begin
            axi_awready_o <= 1'b1;
            axi_wready_o  <= 1'b1;
            axi_bvalid_o  <= 1'b1;
            wr_state_q    <= WR_RESP;
          end
        end
        default: begin
          axi_awready_o <= 1'b0;  // single-cycle ready pulse
          axi_wready_o  <= 1'b0;
          if (axi_bready_i) begin
            axi_bvalid_o <= 1'b0;
            wr_state_q   <= WR_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge fixed_clk_i) begin
    if (wr_go) axi_bid_o <= axi_awid_i;
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      ier_q      <= 1'b0;
      dlab_q     <= 1'b0;
      baud_div_o <= BAUD_DIV_INIT;
    end else if (wr_go) begin
      case (wr_idx)
        REG_IER:      if (!dlab_q) ier_q <= axi_wdata_i[0];
        REG_LCR:      dlab_q <= axi_wdata_i[LCR_DLAB_BIT];  // other lcr fields not kept
        REG_BAUD_DIV: if (dlab_q) baud_div_o <= axi_wdata_i[15:0];
        default:      ;  // unmapped or thr, nothing to store
      endcase
    end
  end

  always_comb begin
    lsr_word               = '0;
    lsr_word[LSR_DR_BIT]   = !rx_empty_i;
    lsr_word[LSR_THRE_BIT] = tx_empty_i;
    lsr_word[LSR_TEMT_BIT] = tx_empty_i && !tx_busy_i;
  end

  always_comb begin
    rd_word = '0;
    case (rd_idx)
      REG_RBR_THR:  if (!dlab_q && !rx_empty_i) rd_word = axi_data_t'(rx_data_i);
      REG_IER:      rd_word[0] = ier_q;
      REG_LCR:      rd_word[LCR_DLAB_BIT] = dlab_q;
      REG_LSR:      rd_word = lsr_word;
      REG_BAUD_DIV: if (dlab_q) rd_word = axi_data_t'(baud_div_o);
      default:      rd_word = '0;  // unmapped reads return zero
    endcase
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      rd_state_q    <= RD_IDLE;
      axi_arready_o <= 1'b0;
      axi_rvalid_o  <= 1'b0;
    end else begin
      case (rd_state_q)
        RD_IDLE: begin
          if (rd_go) begin
            axi_arready_o <= 1'b1;
            axi_rvalid_o  <= 1'b1;
            rd_state_q    <= RD_RESP;
          end
        end
        default: begin
          axi_arready_o <= 1'b0;
          if (axi_rready_i) begin
            axi_rvalid_o <= 1'b0;
            rd_state_q   <= RD_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge fixed_clk_i) begin
    if (rd_go) begin
      axi_rid_o   <= axi_arid_i;
      axi_rdata_o <= rd_word;  // held until rready
    end
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) read_interrupt_o <= 1'b0;
    else read_interrupt_o <= !rx_empty_i && ier_q;
  end

endmodule

`default_nettype wire

// ==== hw/axil_uart_top.sv ====
// axi4-lite uart top level, connects the register block, both FIFOs and the serial engines
`timescale 1ns/1ps
`default_nettype none

module axil_uart_top import uart_pkg::*; (
  input  logic      fixed_clk_i,
  input  logic      axi_aresetn_i,
  input  axi_addr_t axi_awaddr_i,
  input  axi_id_t   axi_awid_i,
  input  logic      axi_awvalid_i,
  output logic      axi_awready_o,
  input  axi_data_t axi_wdata_i,
  input  logic      axi_wvalid_i,
  output logic      axi_wready_o,
  output logic      axi_bvalid_o,
  output axi_id_t   axi_bid_o,
  output axi_resp_t axi_bresp_o,
  input  logic      axi_bready_i,
  input  axi_addr_t axi_araddr_i,
  input  axi_id_t   axi_arid_i,
  input  logic      axi_arvalid_i,
  output logic      axi_arready_o,
  output logic      axi_rvalid_o,
  output axi_id_t   axi_rid_o,
  output axi_data_t axi_rdata_o,
  output axi_resp_t axi_rresp_o,
  input  logic      axi_rready_i,
  input  logic      uart_rx_i,
  output logic      uart_tx_o,
  output logic      read_interrupt_o
);

  logic       tx_push;
  uart_byte_t tx_wr_data;
  logic       tx_full;
  logic       tx_empty;
  logic       tx_busy;
  logic       tx_pop;
  uart_byte_t tx_front;
  logic       rx_push;
  uart_byte_t rx_wr_data;
  logic       rx_pop;
  logic       rx_empty;
  uart_byte_t rx_front;
  baud_div_t  baud_div;

  axil_uart_regs regs_i (
    .fixed_clk_i      (fixed_clk_i),
    .axi_aresetn_i    (axi_aresetn_i),
    .axi_awaddr_i     (axi_awaddr_i),
    .axi_awid_i       (axi_awid_i),
    .axi_awvalid_i    (axi_awvalid_i),
    .axi_awready_o    (axi_awready_o),
    .axi_wdata_i      (axi_wdata_i),
    .axi_wvalid_i     (axi_wvalid_i),
    .axi_wready_o     (axi_wready_o),
    .axi_bvalid_o     (axi_bvalid_o),
    .axi_bid_o        (axi_bid_o),
    .axi_bresp_o      (axi_bresp_o),
    .axi_bready_i     (axi_bready_i),
    .axi_araddr_i     (axi_araddr_i),
    .axi_arid_i       (axi_arid_i),
    .axi_arvalid_i    (axi_arvalid_i),
    .axi_arready_o    (axi_arready_o),
    .axi_rvalid_o     (axi_rvalid_o),
    .axi_rid_o        (axi_rid_o),
    .axi_rdata_o      (axi_rdata_o),
    .axi_rresp_o      (axi_rresp_o),
    .axi_rready_i     (axi_rready_i),
    .tx_push_o        (tx_push),
    .tx_data_o        (tx_wr_data),
    .tx_full_i        (tx_full),
    .tx_empty_i       (tx_empty),
    .tx_busy_i        (tx_busy),
    .rx_pop_o         (rx_pop),
    .rx_empty_i       (rx_empty),
    .rx_data_i        (rx_front),
    .baud_div_o       (baud_div),
    .read_interrupt_o (read_interrupt_o)
  );

  uart_fifo tx_fifo_i (
    .fixed_clk_i   (fixed_clk_i),
    .axi_aresetn_i (axi_aresetn_i),
    .push_i        (tx_push),
    .pop_i         (tx_pop),
    .data_i        (tx_wr_data),
    .data_o        (tx_front),
    .full_o        (tx_full),
    .empty_o       (tx_empty)
  );

  uart_fifo rx_fifo_i (
    .fixed_clk_i   (fixed_clk_i),
    .axi_aresetn_i (axi_aresetn_i),
    .push_i        (rx_push),
    .pop_i         (rx_pop),
    .data_i        (rx_wr_data),
    .data_o        (rx_front),
    .full_o        (),          // overflow bytes are simply lost
    .empty_o       (rx_empty)
  );

  uart_tx tx_i (
    .fixed_clk_i   (fixed_clk_i),
    .axi_aresetn_i (axi_aresetn_i),
    .baud_div_i    (baud_div),
    .fifo_empty_i  (tx_empty),
    .fifo_data_i   (tx_front),
    .fifo_pop_o    (tx_pop),
    .busy_o        (tx_busy),
    .uart_tx_o     (uart_tx_o)
  );

  uart_rx rx_i (
    .fixed_clk_i   (fixed_clk_i),
    .axi_aresetn_i (axi_aresetn_i),
    .baud_div_i    (baud_div),
    .uart_rx_i     (uart_rx_i),
    .push_o        (rx_push),
    .data_o        (rx_wr_data)
  );

endmodule

`default_nettype wire

// ==== verification/axil_uart_assertions.sv ====
// concurrent checks on the axi4-lite handshake and the read interrupt, bound into the register block
`timescale 1ns/1ps
`default_nettype none

module axil_uart_assertions import uart_pkg::*; (
  input logic      fixed_clk_i,
  input logic      axi_aresetn_i,
  input logic      awready_i,
  input logic      wready_i,
  input logic      bvalid_i,
  input logic      bready_i,
  input axi_id_t   bid_i,
  input logic      rvalid_i,
  input logic      rready_i,
  input axi_id_t   rid_i,
  input axi_data_t rdata_i,
  input logic      wr_go_i,
  input logic      rx_empty_i,
  input logic      ier_i,
  input logic      irq_i
);

  logic fail_seen = 1'b0;  // polled by the testbench

  bvalid_hold: assert property (@(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bid_i))
  else begin
    fail_seen = 1'b1;
    $error("bvalid or bid changed before bready");
  end

  rvalid_hold: assert property (@(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rid_i) && $stable(rdata_i))
  else begin
    fail_seen = 1'b1;
    $error("rvalid, rid or rdata changed before rready");
  end

  // each accepted write raises bvalid once, together with the ready pulses
  write_resp: assert property (@(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    wr_go_i |=> $rose(bvalid_i) && awready_i && wready_i)
  else begin
    fail_seen = 1'b1;
    $error("accepted write did not raise bvalid");
  end

  resp_source: assert property (@(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    $rose(bvalid_i) |-> $past(wr_go_i))
  else begin
    fail_seen = 1'b1;
    $error("bvalid rose without an accepted write");
  end

  irq_timing: assert property (@(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    irq_i == $past(!rx_empty_i && ier_i))
  else begin
    fail_seen = 1'b1;
    $error("read interrupt does not follow rx data and ier one cycle late");
  end

endmodule

bind axil_uart_regs axil_uart_assertions props_i (
  .fixed_clk_i   (fixed_clk_i),
  .axi_aresetn_i (axi_aresetn_i),
  .awready_i     (axi_awready_o),
  .wready_i      (axi_wready_o),
  .bvalid_i      (axi_bvalid_o),
  .bready_i      (axi_bready_i),
  .bid_i         (axi_bid_o),
  .rvalid_i      (axi_rvalid_o),
  .rready_i      (axi_rready_i),
  .rid_i         (axi_rid_o),
  .rdata_i       (axi_rdata_o),
  .wr_go_i       (wr_go),
  .rx_empty_i    (rx_empty_i),
  .ier_i         (ier_q),
  .irq_i         (read_interrupt_o)
);

`default_nettype wire

// ==== verification/axil_uart_tb.sv ====
// testbench for the axi4-lite uart that drives the bus and the serial line and checks both directions
`timescale 1ns/1ps
`default_nettype none

module axil_uart_tb import uart_pkg::*; ();

  localparam int unsigned DIV      = 8;   // divisor used for all serial traffic
  localparam int unsigned FRAMES   = 25;  // 23 frames plus two frame times of idle check
  localparam int unsigned BUS_OPS  = 50;
  localparam int unsigned LIMIT_NS = FRAMES * 10 * DIV * 40 * 2 + BUS_OPS * 8 * 40 + 5 * 40;

  logic       fixed_clk_i;
  logic       axi_aresetn_i;
  axi_addr_t  axi_awaddr_i;
  axi_id_t    axi_awid_i;
  logic       axi_awvalid_i;
  logic       axi_awready_o;
  axi_data_t  axi_wdata_i;
  logic       axi_wvalid_i;
  logic       axi_wready_o;
  logic       axi_bvalid_o;
  axi_id_t    axi_bid_o;
  axi_resp_t  axi_bresp_o;
  logic       axi_bready_i;
  axi_addr_t  axi_araddr_i;
  axi_id_t    axi_arid_i;
  logic       axi_arvalid_i;
  logic       axi_arready_o;
  logic       axi_rvalid_o;
  axi_id_t    axi_rid_o;
  axi_data_t  axi_rdata_o;
  axi_resp_t  axi_rresp_o;
  logic       axi_rready_i;
  logic       uart_rx_i;
  logic       uart_tx_o;
  logic       read_interrupt_o;
  logic [31:0] lfsr;
  axi_id_t    next_id;
  uart_byte_t exp_tx[$];
  uart_byte_t got_tx[$];

  axil_uart_top dut_i (.*);

  always #20 fixed_clk_i = ~fixed_clk_i;

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else report_failure($sformatf("error: %s is 0x%h, expected 0x%h", name, got, exp));
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  task automatic draw_byte(output uart_byte_t b);
    b = '0;
    repeat (8) begin
      lfsr = lfsr_next(lfsr);
      b = {b[6:0], lfsr[0]};
    end
  endtask

  task automatic axi_write(input logic [2:0] idx, input axi_data_t data);
    axi_id_t id;
    id = next_id;
    next_id = next_id + 1'b1;
    @(negedge fixed_clk_i);
    axi_awaddr_i  = {idx, 2'b00};
    axi_awid_i    = id;
    axi_wdata_i   = data;
    axi_awvalid_i = 1'b1;
    axi_wvalid_i  = 1'b1;
    @(negedge fixed_clk_i);
    while (!axi_awready_o) @(negedge fixed_clk_i);  // stalls while the tx fifo is full
    axi_awvalid_i = 1'b0;
    axi_wvalid_i  = 1'b0;
    check_equal("axi_wready_o", 32'(axi_wready_o), 32'h1);
    check_equal("axi_bvalid_o", 32'(axi_bvalid_o), 32'h1);
    check_equal("axi_bid_o", 32'(axi_bid_o), 32'(id));
    check_equal("axi_bresp_o", 32'(axi_bresp_o), 32'(RESP_OKAY));
    @(negedge fixed_clk_i);  // one cycle without bready
    axi_bready_i = 1'b1;
    @(negedge fixed_clk_i);
    axi_bready_i = 1'b0;
  endtask

  task automatic axi_read(input logic [2:0] idx, output axi_data_t data);
    axi_id_t id;
    id = next_id;
    next_id = next_id + 1'b1;
    @(negedge fixed_clk_i);
    axi_araddr_i  = {idx, 2'b00};
    axi_arid_i    = id;
    axi_arvalid_i = 1'b1;
    @(negedge fixed_clk_i);
    while (!axi_arready_o) @(negedge fixed_clk_i);
    axi_arvalid_i = 1'b0;
    check_equal("axi_rvalid_o", 32'(axi_rvalid_o), 32'h1);
    check_equal("axi_rid_o", 32'(axi_rid_o), 32'(id));
    check_equal("axi_rresp_o", 32'(axi_rresp_o), 32'(RESP_OKAY));
    data = axi_rdata_o;
    @(negedge fixed_clk_i);
    axi_rready_i = 1'b1;
    @(negedge fixed_clk_i);
    axi_rready_i = 1'b0;
  endtask

  task automatic read_expect(input logic [2:0] idx, input axi_data_t exp, input string what);
    axi_data_t data;
    axi_read(idx, data);
    check_equal({"axi_rdata_o ", what}, data, exp);
  endtask

  task automatic send_frame(input uart_byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};  // stop bit on top and start bit in bit 0
    for (int i = 0; i < 10; i++) begin
      @(negedge fixed_clk_i);
      uart_rx_i = frame[i];
      repeat (DIV - 1) @(negedge fixed_clk_i);
    end
  endtask

  task automatic check_tx_stream();
    uart_byte_t got;
    uart_byte_t exp;
    while (got_tx.size() < exp_tx.size()) @(negedge fixed_clk_i);
    while (exp_tx.size() > 0) begin
      got = got_tx.pop_front();
      exp = exp_tx.pop_front();
      check_equal("uart_tx_o byte", 32'(got), 32'(exp));
    end
  endtask

  // decodes frames on uart_tx_o by sampling near the middle of each bit
  always begin : tx_monitor
    uart_byte_t b;
    @(negedge uart_tx_o);
    repeat (DIV / 2) @(negedge fixed_clk_i);
    assert (uart_tx_o === 1'b0) else report_failure("start bit on uart_tx_o did not stay low");
    for (int i = 0; i < 8; i++) begin
      repeat (DIV) @(negedge fixed_clk_i);
      b[i] = uart_tx_o;
    end
    repeat (DIV) @(negedge fixed_clk_i);
    assert (uart_tx_o === 1'b1) else report_failure("stop bit on uart_tx_o was low");
    got_tx.push_back(b);
  end

  always @(negedge fixed_clk_i) begin
    if (dut_i.regs_i.props_i.fail_seen) report_failure("a bound protocol assertion failed");
  end

  initial begin
    #(LIMIT_NS);
    report_failure("watchdog timeout, the tests did not finish in time");
  end

  initial begin
    axi_data_t  lsr_idle;
    axi_data_t  lsr_ready;
    axi_data_t  dlab_word;
    uart_byte_t b;
    uart_byte_t rx_bytes[4];
    fixed_clk_i   = 1'b0;
    axi_aresetn_i = 1'b0;
    axi_awaddr_i  = '0;
    axi_awid_i    = '0;
    axi_awvalid_i = 1'b0;
    axi_wdata_i   = '0;
    axi_wvalid_i  = 1'b0;
    axi_bready_i  = 1'b0;
    axi_araddr_i  = '0;
    axi_arid_i    = '0;
    axi_arvalid_i = 1'b0;
    axi_rready_i  = 1'b0;
    uart_rx_i     = 1'b1;  // idle line
    lfsr          = 32'hfceaf113;
    next_id       = 4'h3;
    lsr_idle      = '0;
    lsr_idle[LSR_THRE_BIT] = 1'b1;
    lsr_idle[LSR_TEMT_BIT] = 1'b1;
    lsr_ready     = lsr_idle;
    lsr_ready[LSR_DR_BIT]  = 1'b1;
    dlab_word     = '0;
    dlab_word[LCR_DLAB_BIT] = 1'b1;
    repeat (5) @(negedge fixed_clk_i);
    axi_aresetn_i = 1'b1;

    // reset values
    check_equal("axi_awready_o wready bvalid arready rvalid",
                32'({axi_awready_o, axi_wready_o, axi_bvalid_o, axi_arready_o, axi_rvalid_o}),
                32'h0);
    check_equal("read_interrupt_o", 32'(read_interrupt_o), 32'h0);
    check_equal("uart_tx_o", 32'(uart_tx_o), 32'h1);
    read_expect(REG_LSR, lsr_idle, "lsr after reset");

    // divisor setup then six bytes out
    axi_write(REG_LCR, dlab_word);
    axi_write(REG_BAUD_DIV, DIV);
    read_expect(REG_BAUD_DIV, DIV, "baud divisor");
    axi_write(REG_LCR, '0);
    repeat (6) begin
      draw_byte(b);
      exp_tx.push_back(b);
      axi_write(REG_RBR_THR, 32'(b));
    end
    check_tx_stream();
    repeat (DIV) @(negedge fixed_clk_i);  // rest of the last stop bit
    read_expect(REG_LSR, lsr_idle, "lsr after transmit");

    // twelve writes overrun the 8-deep fifo and stall the bus
    repeat (12) begin
      draw_byte(b);
      exp_tx.push_back(b);
      axi_write(REG_RBR_THR, 32'(b));
    end
    check_tx_stream();

    // receive path with the interrupt enabled
    axi_write(REG_IER, 32'h1);
    for (int i = 0; i < 4; i++) begin
      draw_byte(rx_bytes[i]);
      send_frame(rx_bytes[i]);
    end
    repeat (2) @(negedge fixed_clk_i);
    check_equal("read_interrupt_o", 32'(read_interrupt_o), 32'h1);
    read_expect(REG_LSR, lsr_ready, "lsr with rx data");
    for (int i = 0; i < 4; i++) begin
      read_expect(REG_RBR_THR, 32'(rx_bytes[i]), "rbr");
    end
    read_expect(REG_LSR, lsr_idle, "lsr after rbr reads");
    check_equal("read_interrupt_o", 32'(read_interrupt_o), 32'h0);

    // dlab gating and unmapped indices
    axi_write(REG_LCR, dlab_word);
    axi_write(REG_RBR_THR, 32'ha5);
    draw_byte(b);
    send_frame(b);
    read_expect(REG_RBR_THR, '0, "rbr with dlab set");
    repeat (20 * DIV) @(negedge fixed_clk_i);
    assert (got_tx.size() == 0) else report_failure("a thr write with dlab set was transmitted");
    axi_write(REG_LCR, '0);
    check_equal("read_interrupt_o", 32'(read_interrupt_o), 32'h1);
    axi_write(REG_IER, 32'h0);  // interrupt drops with data still waiting
    check_equal("read_interrupt_o", 32'(read_interrupt_o), 32'h0);
    read_expect(REG_RBR_THR, 32'(b), "rbr after dlab cleared");
    read_expect(3'd2, '0, "unmapped index 2");
    read_expect(3'd4, '0, "unmapped index 4");
    read_expect(3'd6, '0, "unmapped index 6");

    if (dut_i.regs_i.props_i.fail_seen) begin
      report_failure("a bound protocol assertion failed");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== compile.f ====
hw/uart_pkg.sv
hw/uart_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/axil_uart_regs.sv
hw/axil_uart_top.sv
verification/axil_uart_assertions.sv
verification/axil_uart_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --assert --timing --timescale 1ns/1ps -f compile.f \
	  --top-module axil_uart_tb -Mdir obj_dir
	out=$$(./obj_dir/Vaxil_uart_tb +verilator+error+limit+100); echo "$$out"; \
	  echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
